// ==== motors_pkg.sv ====
/*
 * Shared constants for the plotter motion path.
 * Holds the command word layout, the command buffer depth, the servo and
 * stepper timing, and the sequencer state type. Every design file
 * pulls what it needs from here by a wildcard import.
 */
package motors_pkg;

	// ----------------------------------------------------------------------
	// command word: servo_pos[19:12] | dir[11] | steps[10:0]
	// ----------------------------------------------------------------------
	localparam int cmd_w     = 20;
	localparam int pos_lsb   = 12;   // servo position field
	localparam int pos_w     = 8;
	localparam int dir_bit   = 11;   // stepper direction
	localparam int steps_lsb = 0;    // step count field
	localparam int steps_w   = 11;
	localparam int drv_w     = 11;   // driver operand, wider of the two fields

	// command buffer
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = 2;

	// ----------------------------------------------------------------------
	// driver timing, all in ticks
	// ----------------------------------------------------------------------
	localparam int servo_period  = 64;                       // ticks per pwm frame
	localparam int servo_settle  = 2;                        // frames before done
	localparam int servo_frame_w = $clog2(servo_period);     // frame counter
	localparam int settle_w      = $clog2(servo_settle + 1); // settle frame counter
	localparam int step_period   = 8;                        // ticks per step
	localparam int step_high     = 4;                        // step pulse width
	localparam int step_ph_w     = $clog2(step_period);      // step phase counter

	// sequencer states, servo strictly before steppers
	typedef enum logic [2:0] {
		idle,
		pop,
		trig_servo,
		wait_servo,
		trig_steppers,
		wait_steppers,
		done
	} seq_state_t;

endpackage : motors_pkg

// ==== motor_drv_if.sv ====
/*
 * Trigger / ready / done handshake between the sequencer and one motor
 * driver. The sequencer holds trigger until rdy falls, the driver pulses
 * done for one tick at the end and raises rdy on the tick after.
 */
`timescale 1ns/1ps

interface motor_drv_if
	import motors_pkg::*;
();

	logic             trigger;  // held until rdy drops
	logic             rdy;      // low while a command runs
	logic             done;     // one tick at completion
	logic [drv_w-1:0] operand;  // position or step count
	logic             dir;      // stepper only, servo ignores it

	// sequencer side
	modport seq (
		output trigger, operand, dir,
		input  rdy, done
	);

	// driver side
	modport drv (
		input  trigger, operand, dir,
		output rdy, done
	);

endinterface : motor_drv_if

// ==== cmd_fifo.sv ====
/*
 * Small first-word-fall-through command buffer.
 * The host writes with wr_en, the sequencer pops with rd_en; rd_data is
 * valid whenever empty is low. A write while full is dropped.
 */
`timescale 1ns/1ps

module cmd_fifo
	import motors_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             wr_en,
	input  logic             rd_en,
	input  logic [cmd_w-1:0] wr_data,
	output logic [cmd_w-1:0] rd_data,
	output logic             full,
	output logic             empty
);

	logic [cmd_w-1:0]      mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_ptr_w:0]   count;   // one bit wider, holds fifo_depth
	logic                  wr_ok;
	logic                  rd_ok;

	assign wr_ok = wr_en && !full;   // overflow writes are lost
	assign rd_ok = rd_en && !empty;

	assign full    = (count == fifo_depth);
	assign empty   = (count == 0);
	assign rd_data = mem[rd_ptr];    // fall-through head word

	// storage
	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// pointers and occupancy, depth is a power of two so pointers just wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;   // none, or write and pop together
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// host must wait on full, sequencer must only pop a waiting word
	// ----------------------------------------------------------------------
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> !full)
		else $error("command written while buffer full");

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		rd_en |-> !empty)
		else $error("command popped from empty buffer");

endmodule : cmd_fifo

// ==== motors_sequencer.sv ====
/*
 * Motion sequencer. Pops one command at a time from the buffer, sends the
 * servo position first and starts the stepper only after the servo has
 * reported done. Advances on tick only; busy covers pop through done.
 */
`timescale 1ns/1ps

module motors_sequencer
	import motors_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             tick,
	input  logic             cmd_empty,
	input  logic [cmd_w-1:0] cmd_data,
	output logic             cmd_pop,
	output logic             busy,
	motor_drv_if.seq         servo,
	motor_drv_if.seq         steppers
);

	seq_state_t       state;
	seq_state_t       nxt_state;
	logic [cmd_w-1:0] cmd_q;       // command being executed
	logic             servo_fin;   // servo done seen for this command

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------
	always_comb begin
		nxt_state = state;
		case (state)
		idle: begin
			if (!cmd_empty) nxt_state = pop;
		end
		pop: begin
			nxt_state = trig_servo;   // word latched on this tick
		end
		trig_servo: begin
			if (!servo.rdy) nxt_state = wait_servo;   // accepted
		end
		wait_servo: begin
			// done is only a pulse so the flag keeps it if the stepper is late
			if ((servo.done || servo_fin) && steppers.rdy) nxt_state = trig_steppers;
		end
		trig_steppers: begin
			if (!steppers.rdy) nxt_state = wait_steppers;
		end
		wait_steppers: begin
			if (steppers.done) nxt_state = done;
		end
		done: begin
			nxt_state = idle;
		end
		default: nxt_state = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end
		else if (tick) begin
			state <= nxt_state;
		end
	end

	// remember servo completion across the wait
	always_ff @(posedge clk) begin
		if (reset) begin
			servo_fin <= 1'b0;
		end
		else if (state == trig_servo) begin
			servo_fin <= 1'b0;
		end
		else if (state == wait_servo && servo.done) begin
			servo_fin <= 1'b1;
		end
	end

	// command word held for the whole sequence
	always_ff @(posedge clk) begin
		if (cmd_pop) cmd_q <= cmd_data;
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign cmd_pop = tick && (state == pop);   // single cycle
	assign busy    = (state != idle);

	assign servo.trigger    = (state == trig_servo);
	assign servo.operand    = drv_w'(cmd_q[pos_lsb +: pos_w]);   // zero extended
	assign servo.dir        = 1'b0;                              // unused by servo

	assign steppers.trigger = (state == trig_steppers);
	assign steppers.operand = cmd_q[steps_lsb +: steps_w];
	assign steppers.dir     = cmd_q[dir_bit];

	// stepper only starts once the servo is back to ready
	a_servo_first: assert property (@(posedge clk) disable iff (reset)
		steppers.trigger |-> servo.rdy)
		else $error("stepper triggered before servo completed");

endmodule : motors_sequencer

// ==== servo_pwm.sv ====
/*
 * Hobby servo pulse generator. A free running frame counter spans
 * servo_period ticks; pwm is high for the first pos ticks of every frame.
 * A new position is accepted through the drv handshake and done follows
 * after servo_settle frame wraps.
 */
`timescale 1ns/1ps

module servo_pwm
	import motors_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     tick,
	motor_drv_if.drv ctl,
	output logic     pwm
);

	logic [servo_frame_w-1:0] frame_cnt;   // position within frame
	logic [pos_w-1:0]         pos_q;       // held pulse width in ticks
	logic [settle_w-1:0]      settle_cnt;  // frames still to wait
	logic                     frame_wrap;

	assign frame_wrap = tick && (frame_cnt == servo_frame_w'(servo_period - 1));

	// ----------------------------------------------------------------------
	// frame counter, never stops
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= '0;
		end
		else if (frame_wrap) begin
			frame_cnt <= '0;
		end
		else if (tick) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// pos 0 keeps the line low, pos >= period keeps it high
	assign pwm = (pos_w'(frame_cnt) < pos_q);

	// ----------------------------------------------------------------------
	// handshake and settle time
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ctl.rdy    <= 1'b1;
			ctl.done   <= 1'b0;
			pos_q      <= '0;    // no pulses until first command
			settle_cnt <= '0;
		end
		else if (tick) begin
			if (ctl.done) begin
				ctl.done <= 1'b0;   // one tick only
				ctl.rdy  <= 1'b1;
			end
			else if (ctl.rdy && ctl.trigger) begin
				ctl.rdy    <= 1'b0;                   // accept
				pos_q      <= ctl.operand[pos_w-1:0];
				settle_cnt <= settle_w'(servo_settle);
			end
			else if (!ctl.rdy && frame_wrap) begin
				if (settle_cnt == settle_w'(1)) begin
					ctl.done <= 1'b1;   // last settle frame passed
				end
				else begin
					settle_cnt <= settle_cnt - 1'b1;
				end
			end
		end
	end

endmodule : servo_pwm

// ==== stepper_pulse.sv ====
/*
 * Step and direction generator for one stepper axis.
 * On acceptance the step count and direction are latched, then one step
 * pulse of step_high ticks is issued every step_period ticks until the
 * count runs out. A zero count completes on the next tick.
 */
`timescale 1ns/1ps

module stepper_pulse
	import motors_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     tick,
	motor_drv_if.drv ctl,
	output logic     step,
	output logic     dir_out
);

	logic [steps_w-1:0]   remaining;   // steps left including current
	logic [step_ph_w-1:0] phase;       // tick within the step period

	// ----------------------------------------------------------------------
	// step pulse at the start of every period while steps remain
	// ----------------------------------------------------------------------
	assign step = !ctl.rdy && (remaining != '0) && (phase < step_ph_w'(step_high));

	always_ff @(posedge clk) begin
		if (reset) begin
			ctl.rdy   <= 1'b1;
			ctl.done  <= 1'b0;
			remaining <= '0;
			phase     <= '0;
			dir_out   <= 1'b0;
		end
		else if (tick) begin
			if (ctl.done) begin
				ctl.done <= 1'b0;
				ctl.rdy  <= 1'b1;   // ready again the tick after done
			end
			else if (ctl.rdy && ctl.trigger) begin
				// accept and start the first pulse right away
				ctl.rdy   <= 1'b0;
				remaining <= ctl.operand[steps_w-1:0];
				phase     <= '0;
				dir_out   <= ctl.dir;   // held until next command
			end
			else if (!ctl.rdy) begin
				if (remaining == '0) begin
					ctl.done <= 1'b1;   // all steps out or zero count
				end
				else if (phase == step_ph_w'(step_period - 1)) begin
					phase     <= '0;   // period over
					remaining <= remaining - 1'b1;
				end
				else begin
					phase <= phase + 1'b1;
				end
			end
		end
	end

endmodule : stepper_pulse

// ==== motors_top.sv ====
/*
 * Motion command path top level.
 * Host writes go into the command buffer, the sequencer drains it and
 * drives the servo first, then the stepper. Work is finished when busy is
 * low and empty is high.
 */
`timescale 1ns/1ps

module motors_top
	import motors_pkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             tick,       // shared slow enable
	input  logic             wr_en,      // host write strobe
	input  logic [cmd_w-1:0] wr_data,
	output logic             full,       // host must hold off
	output logic             empty,
	output logic             busy,
	output logic             servo_pwm,
	output logic             step,
	output logic             dir
);

	logic [cmd_w-1:0] cmd_data;   // buffer head
	logic             cmd_pop;

	// one handshake per driver
	motor_drv_if servo_if ();
	motor_drv_if step_if ();

	cmd_fifo i_cmd_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wr_en),
		.rd_en   (cmd_pop),
		.wr_data (wr_data),
		.rd_data (cmd_data),
		.full    (full),
		.empty   (empty)
	);

	motors_sequencer i_sequencer (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.cmd_empty (empty),
		.cmd_data  (cmd_data),
		.cmd_pop   (cmd_pop),
		.busy      (busy),
		.servo     (servo_if.seq),
		.steppers  (step_if.seq)
	);

	servo_pwm i_servo_pwm (
		.clk   (clk),
		.reset (reset),
		.tick  (tick),
		.ctl   (servo_if.drv),
		.pwm   (servo_pwm)
	);

	stepper_pulse i_stepper (
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.ctl     (step_if.drv),
		.step    (step),
		.dir_out (dir)
	);

endmodule : motors_top

// ==== motors_tb.sv ====
/*
 * Self-checking testbench for the plotter motion path.
 * Reads command words and expected results from motors_stim.txt, writes
 * them through the host port and watches step, dir and servo_pwm.
 * Names starting with buf_ are written back to back behind a running
 * command while every other line waits for the DUT to go idle first.
 */
`timescale 1ns/1ps

module motors_tb
	import motors_pkg::*;
();

	localparam int         reset_cycles = 8;
	localparam logic [1:0] tick_pattern = 2'b10;   // tick on every second cycle

	logic             clk;
	logic             reset;
	logic             tick;
	logic             tick_phase;
	logic             wr_en;
	logic [cmd_w-1:0] wr_data;
	logic             full;
	logic             empty;
	logic             busy;
	logic             servo_pwm;
	logic             step;
	logic             dir;

	// stim contents
	string            names[$];
	logic [cmd_w-1:0] cmds[$];
	int               exp_steps[$];
	logic             exp_dir[$];
	int               exp_width[$];
	int               n_cmds;
	int               limit_cycles = 0;
	int               cycle_count = 0;

	// monitor state
	int   tick_pos;       // tb copy of the servo frame position
	int   frame_acc;      // high ticks so far in this frame
	int   last_frame_w;   // high ticks of last complete frame
	int   pwm_rises;      // frame starts since busy rose
	int   step_cnt;
	int   cmd_started = 0;
	int   checked_count = 0;
	logic prev_busy;
	logic prev_step;
	logic prev_pwm;

	motors_top i_motors_top (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.full      (full),
		.empty     (empty),
		.busy      (busy),
		.servo_pwm (servo_pwm),
		.step      (step),
		.dir       (dir)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;   // 10 ns period

	// tick from a fixed two cycle pattern driven 1 ns after the edge
	always @(posedge clk) begin
		#1;
		tick_phase = !tick_phase;
		tick       = tick_pattern[tick_phase];
	end

	// ----------------------------------------------------------------------
	// error reporting and compare tasks
	// ----------------------------------------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic word_compare(input string name, input logic [cmd_w-1:0] exp,
		input logic [cmd_w-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic count_compare(input string name, input logic [steps_w-1:0] exp,
		input logic [steps_w-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	task automatic bit_compare(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// cycle limit set once the stim is loaded
	always @(posedge clk) begin
		cycle_count++;
		if (limit_cycles > 0 && cycle_count > limit_cycles) begin
			abort_run("run did not finish before cycle limit");
		end
	end

	// ----------------------------------------------------------------------
	// stim file
	// ----------------------------------------------------------------------
	task automatic load_stim();
		int               fd;
		int               got;
		int               total_ticks;
		string            line;
		string            nm;
		logic [cmd_w-1:0] word;
		int               st;
		int               dr;
		int               pw;
		total_ticks = 0;
		fd = $fopen("motors_stim.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open motors_stim.txt");
		end
		else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					got = $sscanf(line, "%s %h %d %d %d", nm, word, st, dr, pw);
					if (got != 5) begin
						abort_run({"malformed stim line: ", line});
					end
					names.push_back(nm);
					cmds.push_back(word);
					exp_steps.push_back(st);
					exp_dir.push_back(dr[0]);
					exp_width.push_back(pw);
					total_ticks += 3 * servo_period + st * step_period;   // settle plus moves
				end
			end
			$fclose(fd);
			n_cmds = names.size();
			// two cycles per tick plus 20% margin
			limit_cycles = total_ticks * 2 * 12 / 10 + reset_cycles;
		end
	endtask

	function automatic bit is_burst_entry(input string name);
		return (name.len() >= 4 && name.substr(0, 3) == "buf_");
	endfunction

	// ----------------------------------------------------------------------
	// host side actions at posedge + 1
	// ----------------------------------------------------------------------
	task automatic host_write(input logic [cmd_w-1:0] word);
		wr_en   = 1'b1;
		wr_data = word;
		@(posedge clk);
		#1;
		wr_en   = 1'b0;
	endtask

	task automatic settle_idle();
		while (busy || !empty) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic await_pop();
		while (!empty) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic full_backoff();
		while (full) begin   // host holds off
			@(posedge clk);
			#1;
		end
	endtask

	// ----------------------------------------------------------------------
	// monitor sampled at negedge where all outputs are settled
	// ----------------------------------------------------------------------
	task automatic note_step();
		int idx;
		idx = cmd_started - 1;
		if (idx < 0 || !busy) begin
			abort_run("step pulse while no command was running");
		end
		else begin
			step_cnt++;
			bit_compare({names[idx], " dir at step"}, exp_dir[idx], dir);
			// servo must have settled before any motion
			if (exp_width[idx] != 0 && pwm_rises < servo_settle) begin
				abort_run({"step pulse before the servo settled in ", names[idx]});
			end
		end
	endtask

	task automatic close_command();
		int               idx;
		logic [cmd_w-1:0] obs;
		idx = cmd_started - 1;
		count_compare({names[idx], " steps"}, exp_steps[idx], step_cnt);
		bit_compare({names[idx], " dir"}, exp_dir[idx], dir);
		count_compare({names[idx], " pwm width"}, exp_width[idx], last_frame_w);
		// rebuild the word from what was seen on the pins
		obs                      = '0;
		obs[pos_lsb +: pos_w]     = last_frame_w[pos_w-1:0];
		obs[dir_bit]             = dir;
		obs[steps_lsb +: steps_w] = step_cnt[steps_w-1:0];
		word_compare({names[idx], " observed fields"}, cmds[idx], obs);
		checked_count++;
	endtask

	always @(negedge clk) begin
		if (reset) begin
			tick_pos     = 0;
			frame_acc    = 0;
			last_frame_w = 0;
			pwm_rises    = 0;
			step_cnt     = 0;
			prev_busy    = 1'b0;
			prev_step    = 1'b0;
			prev_pwm     = 1'b0;
		end
		else begin
			// one sample per frame position
			if (tick) begin
				if (servo_pwm) frame_acc++;
				if (tick_pos == servo_period - 1) begin
					last_frame_w = frame_acc;   // frame complete
					frame_acc    = 0;
					tick_pos     = 0;
				end
				else begin
					tick_pos++;
				end
			end
			if (servo_pwm && !prev_pwm) pwm_rises++;
			if (busy && !prev_busy) begin
				cmd_started++;   // new command popped
				step_cnt  = 0;
				pwm_rises = 0;
				if (cmd_started > n_cmds) begin
					abort_run("busy rose with no command left to run");
				end
			end
			if (step && !prev_step) note_step();
			if (!busy && prev_busy) close_command();
			prev_busy = busy;
			prev_step = step;
			prev_pwm  = servo_pwm;
		end
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int i;
		int burst_n;
		reset      = 1'b1;
		tick       = 1'b0;
		tick_phase = 1'b0;
		wr_en      = 1'b0;
		wr_data    = '0;
		burst_n    = 0;
		load_stim();
		if (n_cmds == 0) begin
			abort_run("stim file holds no commands");
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		// outputs idle out of reset
		bit_compare("after_reset empty", 1'b1, empty);
		bit_compare("after_reset full", 1'b0, full);
		bit_compare("after_reset busy", 1'b0, busy);
		bit_compare("after_reset step", 1'b0, step);
		bit_compare("after_reset servo_pwm", 1'b0, servo_pwm);

		for (i = 0; i < n_cmds; i++) begin
			if (is_burst_entry(names[i])) begin
				full_backoff();
				host_write(cmds[i]);
				burst_n++;
				// lead command still running so nothing popped yet
				if (burst_n <= fifo_depth) begin
					bit_compare({names[i], " full"}, burst_n == fifo_depth, full);
				end
			end
			else begin
				settle_idle();
				host_write(cmds[i]);
				await_pop();   // buffer empty again behind it
				burst_n = 0;
			end
		end

		while (checked_count < n_cmds) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		bit_compare("end empty", 1'b1, empty);
		bit_compare("end full", 1'b0, full);
		bit_compare("end busy", 1'b0, busy);
		bit_compare("end step", 1'b0, step);
		$display("All tests passed");
		$finish;
	end

endmodule : motors_tb

// ==== motors_stim.txt ====
# columns: name  command_word(hex, pos[19:12] dir[11] steps[10:0])  steps  dir  pwm_width
# buf_ lines are written back to back behind the line before them
basic_fwd    14805  5   1  20
basic_rev    2800C  12  0  40
pen_zero     00803  3   1  0
zero_steps   21000  0   0  33
lead         0A81E  30  1  10
buf_a        05002  2   0  5
buf_b        3F807  7   1  63
buf_c        01801  1   1  1
buf_d        30000  0   0  48
buf_e        19809  9   1  25
final_move   32004  4   0  50

// ==== flist.f ====
motors_pkg.sv
motor_drv_if.sv
cmd_fifo.sv
motors_sequencer.sv
servo_pwm.sv
stepper_pulse.sv
motors_top.sv
motors_tb.sv
